// ==== flist.f ====
+incdir+logic
logic/ioPkg.sv
logic/wbDecoder.sv
logic/intervalTimer.sv
logic/keyDebounce.sv
logic/displayRegs.sv
logic/ioTop.sv
verif/ioTop_chk.sv
verif/ioTb.sv

// ==== logic/displayRegs.sv ====
`timescale 1ns/10ps
`include "ioSettings.svh"

module displayRegs (
  input  logic            clk,
  input  logic            RESET,
  input  ioPkg::devAcc_t  acc,
  output ioPkg::ioWord_t  rdData,
  output ioPkg::hexSegs_t hexSegs,
  output ioPkg::ledVal_t  ledr
);
  import ioPkg::*;

  hexVal_t hexReg;
  ledVal_t ledReg;
  logic    hexWr, ledWr;

  // Nibble to active-low segment code
  function automatic segCode_t segDecode(logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // Word 0 is the hex value, word 1 the LED pattern
  assign hexWr = acc.stb && acc.we && (acc.ofs == 3'(`IO_OFS_DATA / 4));
  assign ledWr = acc.stb && acc.we && (acc.ofs == 3'(`IO_OFS_CTRL / 4));

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      hexReg <= `IO_HEX_RESET;
      ledReg <= '0;
    end else begin
      if (hexWr) begin
        hexReg <= acc.dat[`IO_HEX_BITS-1:0];
      end
      if (ledWr) begin
        ledReg <= acc.dat[`IO_LEDR_BITS-1:0];
      end
    end
  end

  always_comb begin
    for (int d = 0; d < `IO_DIGITS; d++) begin
      hexSegs[d] = segDecode(hexReg[d*4 +: 4]);
    end
  end

  assign ledr = ledReg;

  assign rdData = (acc.ofs == 3'(`IO_OFS_DATA / 4)) ? ioWord_t'(hexReg) :
                  (acc.ofs == 3'(`IO_OFS_CTRL / 4)) ? ioWord_t'(ledReg) : '0;

endmodule

// ==== logic/intervalTimer.sv ====
`timescale 1ns/10ps
`include "ioSettings.svh"

module intervalTimer (
  input  logic           clk,
  input  logic           RESET,
  input  ioPkg::devAcc_t acc,
  output ioPkg::ioWord_t rdData,
  output logic           timerIrq
);
  import ioPkg::*;

  ioWord_t count;
  ioWord_t limit;
  logic    ready, overrun, irqEn;
  logic    wrap;
  logic    countWr, limitWr, ctrlWr;

  // Wrap happens on the edge after count reaches limit - 1
  assign wrap = (limit != '0) && (count == limit - 1'b1);

  assign countWr = acc.stb && acc.we && (acc.ofs == 3'(`IO_OFS_DATA / 4));
  assign limitWr = acc.stb && acc.we && (acc.ofs == 3'(`IO_OFS_LIMIT / 4));
  assign ctrlWr  = acc.stb && acc.we && (acc.ofs == 3'(`IO_OFS_TCTRL / 4));

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      count   <= '0;
      limit   <= '0;
      ready   <= 1'b0;
      overrun <= 1'b0;
      irqEn   <= 1'b0;
    end else begin
      // A count write wins over the increment
      if (countWr) begin
        count <= acc.dat;
      end else if (wrap) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
      if (limitWr) begin
        limit <= acc.dat;
      end
      // Writing 0 to a flag bit clears it
      if (ctrlWr) begin
        if (!acc.dat[`IO_BIT_READY]) ready <= 1'b0;
        if (!acc.dat[`IO_BIT_OVERRUN]) overrun <= 1'b0;
        irqEn <= acc.dat[`IO_BIT_IE];
      end
      // Wrap event comes last so a concurrent clear does not hide it
      if (wrap) begin
        ready <= 1'b1;
        if (ready) overrun <= 1'b1;
      end
    end
  end

  always_comb begin
    rdData = '0;
    case (acc.ofs)
      3'(`IO_OFS_DATA / 4):  rdData = count;
      3'(`IO_OFS_LIMIT / 4): rdData = limit;
      3'(`IO_OFS_TCTRL / 4): begin
        rdData[`IO_BIT_READY]   = ready;
        rdData[`IO_BIT_OVERRUN] = overrun;
        rdData[`IO_BIT_IE]      = irqEn;
      end
      default: rdData = '0;
    endcase
  end

  assign timerIrq = ready && irqEn;

endmodule

// ==== logic/ioPkg.sv ====
`include "ioSettings.svh"

package ioPkg;

  // Plain vectors with a meaning
  typedef logic [`IO_DATA_BITS-1:0] ioWord_t;
  typedef logic [`IO_ADDR_BITS-1:0] ioAddr_t;
  typedef logic [`IO_HEX_BITS-1:0]  hexVal_t;
  typedef logic [`IO_LEDR_BITS-1:0] ledVal_t;
  typedef logic [`IO_KEY_BITS-1:0]  keyVal_t;

  // Active-low segments, bit 6 is segment g
  typedef logic [`IO_SEG_BITS-1:0] segCode_t;

  // Digit 0 sits in the low bits
  typedef segCode_t [`IO_DIGITS-1:0] hexSegs_t;

  // ==============================
  // Bus structs
  // ==============================
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    ioAddr_t adr;
    ioWord_t dat;
  } wbReq_t;

  typedef struct packed {
    logic    ack;
    ioWord_t dat;
  } wbRsp_t;

  // One access toward one device, ofs is the word index in its window
  typedef struct packed {
    logic       stb;
    logic       we;
    logic [2:0] ofs;
    ioWord_t    dat;
  } devAcc_t;

endpackage

// ==== logic/ioSettings.svh ====
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// ==============================
// Bus widths and device map
// ==============================
`define IO_DATA_BITS      32
`define IO_ADDR_BITS      32
`define IO_HEX_BASE       32'hFFFFF000
`define IO_LEDR_BASE      32'hFFFFF020
`define IO_KEY_BASE       32'hFFFFF080
`define IO_TIMER_BASE     32'hFFFFF100

// Byte offsets within a device window
`define IO_OFS_DATA       0
`define IO_OFS_CTRL       4
`define IO_OFS_LIMIT      4
`define IO_OFS_TCTRL      8

// ==============================
// Device geometry
// ==============================
`define IO_HEX_BITS       24
`define IO_LEDR_BITS      10
`define IO_KEY_BITS       4
`define IO_SEG_BITS       7
`define IO_DIGITS         6

// Clocks between two key samples
`define IO_DEBOUNCE_TICKS 16
`define IO_HEX_RESET      24'hFFFFFF

// Status and control bit positions
`define IO_BIT_READY      0
`define IO_BIT_OVERRUN    1
`define IO_BIT_IE         4

`endif

// ==== logic/ioTop.sv ====
`timescale 1ns/10ps

module ioTop (
  input  logic            clk,
  input  logic            RESET,
  input  ioPkg::wbReq_t   wbReq,
  input  ioPkg::keyVal_t  key,
  output ioPkg::wbRsp_t   wbRsp,
  output ioPkg::hexSegs_t hexSegs,
  output ioPkg::ledVal_t  ledr,
  output logic            intReq
);
  import ioPkg::*;

  devAcc_t displayAcc, keyAcc, timerAcc;
  ioWord_t displayRd, keyRd, timerRd;
  logic    keyIrq, timerIrq;

  // ==============================
  // Bus slave and address decode
  // ==============================
  wbDecoder u_decoder (
    .clk(clk), .RESET(RESET), .wbReq(wbReq),
    .displayRd(displayRd), .keyRd(keyRd), .timerRd(timerRd),
    .wbRsp(wbRsp), .displayAcc(displayAcc), .keyAcc(keyAcc), .timerAcc(timerAcc)
  );

  // ==============================
  // Devices
  // ==============================
  displayRegs u_display (
    .clk(clk), .RESET(RESET), .acc(displayAcc),
    .rdData(displayRd), .hexSegs(hexSegs), .ledr(ledr)
  );

  keyDebounce u_key (
    .clk(clk), .RESET(RESET), .key(key), .acc(keyAcc),
    .rdData(keyRd), .keyIrq(keyIrq)
  );

  intervalTimer u_timer (
    .clk(clk), .RESET(RESET), .acc(timerAcc),
    .rdData(timerRd), .timerIrq(timerIrq)
  );

  // Single interrupt line toward the processor
  assign intReq = keyIrq || timerIrq;

endmodule

// ==== logic/keyDebounce.sv ====
`timescale 1ns/10ps
`include "ioSettings.svh"

module keyDebounce (
  input  logic           clk,
  input  logic           RESET,
  input  ioPkg::keyVal_t key,
  input  ioPkg::devAcc_t acc,
  output ioPkg::ioWord_t rdData,
  output logic           keyIrq
);
  import ioPkg::*;

  localparam int TickBits = $clog2(`IO_DEBOUNCE_TICKS);

  logic [TickBits-1:0] tickCnt;
  logic                tickDone;
  keyVal_t             sample, lastSample;
  keyVal_t             keyData;
  logic                ready, overrun, irqEn;
  logic                dataRd, ctrlWr, load;

  // ==============================
  // Sampling and stability filter
  // ==============================
  assign tickDone = (tickCnt == TickBits'(`IO_DEBOUNCE_TICKS - 1));

  // Two equal samples in a row that differ from the stored level
  assign load = tickDone && (lastSample == sample) && (sample != keyData);

  assign dataRd = acc.stb && !acc.we && (acc.ofs == 3'(`IO_OFS_DATA / 4));
  assign ctrlWr = acc.stb && acc.we && (acc.ofs == 3'(`IO_OFS_CTRL / 4));

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      tickCnt    <= '0;
      sample     <= '0;
      lastSample <= '0;
      keyData    <= '0;
      ready      <= 1'b0;
      overrun    <= 1'b0;
      irqEn      <= 1'b0;
    end else begin
      tickCnt <= tickDone ? '0 : tickCnt + 1'b1;
      if (tickDone) begin
        // Keys are active low on the board
        sample     <= ~key;
        lastSample <= sample;
      end
      if (dataRd) begin
        ready <= 1'b0;
      end
      if (ctrlWr) begin
        if (!acc.dat[`IO_BIT_OVERRUN]) overrun <= 1'b0;
        irqEn <= acc.dat[`IO_BIT_IE];
      end
      if (load) begin
        keyData <= sample;
        // Unread data still pending, flag the loss
        if (ready && !dataRd) begin
          overrun <= 1'b1;
        end else begin
          ready <= 1'b1;
        end
      end
    end
  end

  // ==============================
  // Register read
  // ==============================
  always_comb begin
    rdData = '0;
    if (acc.ofs == 3'(`IO_OFS_DATA / 4)) begin
      rdData = ioWord_t'(keyData);
    end else if (acc.ofs == 3'(`IO_OFS_CTRL / 4)) begin
      rdData[`IO_BIT_READY]   = ready;
      rdData[`IO_BIT_OVERRUN] = overrun;
      rdData[`IO_BIT_IE]      = irqEn;
    end
  end

  assign keyIrq = ready && irqEn;

endmodule

// ==== logic/wbDecoder.sv ====
`timescale 1ns/10ps
`include "ioSettings.svh"

module wbDecoder (
  input  logic            clk,
  input  logic            RESET,
  input  ioPkg::wbReq_t   wbReq,
  input  ioPkg::ioWord_t  displayRd,
  input  ioPkg::ioWord_t  keyRd,
  input  ioPkg::ioWord_t  timerRd,
  output ioPkg::wbRsp_t   wbRsp,
  output ioPkg::devAcc_t  displayAcc,
  output ioPkg::devAcc_t  keyAcc,
  output ioPkg::devAcc_t  timerAcc
);
  import ioPkg::*;

  logic    ackQ;
  ioWord_t datQ;
  logic    take;
  logic    hexHit, ledrHit, keyHit, timerHit;
  ioWord_t rdWord;

  // Word-aligned address inside a window of the given size
  function automatic logic hitWindow(ioAddr_t adr, ioAddr_t base, int unsigned bytes);
    ioAddr_t diff;
    diff = adr - base;
    return (diff < bytes) && (diff[1:0] == 2'b00);
  endfunction

  // A request is taken once, in the cycle before ack
  assign take = wbReq.cyc && wbReq.stb && !ackQ;

  assign hexHit   = hitWindow(wbReq.adr, `IO_HEX_BASE, 4);
  assign ledrHit  = hitWindow(wbReq.adr, `IO_LEDR_BASE, 4);
  assign keyHit   = hitWindow(wbReq.adr, `IO_KEY_BASE, 8);
  assign timerHit = hitWindow(wbReq.adr, `IO_TIMER_BASE, 12);

  // Hex and LEDR share the display block, LEDR appears as its second word
  assign displayAcc = '{stb: take && (hexHit || ledrHit), we: wbReq.we,
                        ofs: ledrHit ? 3'(`IO_OFS_CTRL / 4) : 3'(`IO_OFS_DATA / 4),
                        dat: wbReq.dat};
  assign keyAcc     = '{stb: take && keyHit, we: wbReq.we,
                        ofs: wbReq.adr[4:2], dat: wbReq.dat};
  assign timerAcc   = '{stb: take && timerHit, we: wbReq.we,
                        ofs: wbReq.adr[4:2], dat: wbReq.dat};

  // Unmapped reads return zero
  assign rdWord = (hexHit || ledrHit) ? displayRd :
                  keyHit              ? keyRd     :
                  timerHit            ? timerRd   : '0;

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ackQ <= 1'b0;
    end else begin
      ackQ <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      datQ <= rdWord;
    end
  end

  assign wbRsp = '{ack: ackQ, dat: datQ};

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ioTb -f flist.f -o ioSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/ioSim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

// ==== verif/ioTb.sv ====
`timescale 1ns/10ps
`include "ioSettings.svh"

module ioTb;
  import ioPkg::*;

  localparam ioAddr_t HexAdr   = `IO_HEX_BASE;
  localparam ioAddr_t LedrAdr  = `IO_LEDR_BASE;
  localparam ioAddr_t KeyAdr   = `IO_KEY_BASE + `IO_OFS_DATA;
  localparam ioAddr_t KctrlAdr = `IO_KEY_BASE + `IO_OFS_CTRL;
  localparam ioAddr_t CountAdr = `IO_TIMER_BASE + `IO_OFS_DATA;
  localparam ioAddr_t LimitAdr = `IO_TIMER_BASE + `IO_OFS_LIMIT;
  localparam ioAddr_t TctrlAdr = `IO_TIMER_BASE + `IO_OFS_TCTRL;

  // Active-low codes for nibbles 0 to F
  localparam segCode_t segTable [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001, 7'b0010010,
    7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};

  logic     clk = 1'b0;
  logic     RESET;
  wbReq_t   wbReq;
  keyVal_t  key;
  wbRsp_t   wbRsp;
  hexSegs_t hexSegs;
  ledVal_t  ledr;
  logic     intReq;
  int       cycles = 0;
  logic [31:0] lfsrState = 32'hbf0a;

  ioTop u_ioTop (
    .clk(clk), .RESET(RESET), .wbReq(wbReq), .key(key),
    .wbRsp(wbRsp), .hexSegs(hexSegs), .ledr(ledr), .intReq(intReq)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  // Fibonacci LFSR with taps 32 22 2 1
  // One step for each bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = {lfsrState[30:0],
                   lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
      val = {val[30:0], lfsrState[0]};
    end
    return val;
  endfunction

  function automatic hexSegs_t expSegs(hexVal_t v);
    hexSegs_t s;
    for (int d = 0; d < `IO_DIGITS; d++) begin
      s[d] = segTable[v[d*4 +: 4]];
    end
    return s;
  endfunction

  task automatic reportFail(string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic waitCycles(int n);
    for (int i = 0; i < n; i++) @(negedge clk);
  endtask

  // ==============================
  // Wishbone master
  // ==============================
  task automatic wbAccess(input logic we, input ioAddr_t adr, input ioWord_t wdat,
                          output ioWord_t rdat);
    int waited;
    waited = 0;
    @(negedge clk);
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk);
    while (!wbRsp.ack && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    assert (wbRsp.ack) else reportFail("bus ack wait expired after 10 cycles");
    rdat = wbRsp.dat;
    // Request stays up through the ack cycle and drops in the next one
    @(negedge clk);
    wbReq = '0;
  endtask

  task automatic wbWrite(ioAddr_t adr, ioWord_t dat);
    ioWord_t unused;
    wbAccess(1'b1, adr, dat, unused);
  endtask

  task automatic wbRead(ioAddr_t adr, string what, ioWord_t exp);
    ioWord_t got;
    wbAccess(1'b0, adr, '0, got);
    assert (got === exp)
      else reportFail($sformatf("ERR %0t: %s read %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkOutputs(hexVal_t expHex, ledVal_t expLed, logic expIrq);
    assert (hexSegs === expSegs(expHex))
      else reportFail($sformatf("ERR %0t: hexSegs %h for value %h", $time, hexSegs, expHex));
    assert (ledr === expLed)
      else reportFail($sformatf("ERR %0t: ledr %h, expected %h", $time, ledr, expLed));
    assert (intReq === expIrq)
      else reportFail($sformatf("ERR %0t: intReq %b, expected %b", $time, intReq, expIrq));
  endtask

  task automatic holdKeys(keyVal_t pat);
    @(negedge clk);
    key = pat;
    waitCycles(64);
  endtask

  initial begin
    hexVal_t expHex;
    ledVal_t expLed;
    keyVal_t expKey;
    keyVal_t pat;
    ioWord_t dat;
    ioWord_t rdWord;
    ioWord_t limitVal;
    int      start;
    logic    gotReady;

    RESET = 1'b1;
    wbReq = '0;
    key = 4'hF;
    expHex = `IO_HEX_RESET;
    expLed = '0;
    expKey = '0;
    waitCycles(4);
    RESET = 1'b0;

    // Reset state
    checkOutputs(expHex, expLed, 1'b0);
    wbRead(HexAdr, "hex after reset", ioWord_t'(expHex));
    wbRead(LedrAdr, "ledr after reset", '0);

    // Display writes with read-back
    for (int n = 0; n < 40; n++) begin
      dat = randBits(32);
      if (randBits(1) != 0) begin
        wbWrite(HexAdr, dat);
        expHex = dat[`IO_HEX_BITS-1:0];
        wbRead(HexAdr, "hex", ioWord_t'(expHex));
      end else begin
        wbWrite(LedrAdr, dat);
        expLed = dat[`IO_LEDR_BITS-1:0];
        wbRead(LedrAdr, "ledr", ioWord_t'(expLed));
      end
      checkOutputs(expHex, expLed, 1'b0);
    end

    // Unmapped addresses below the device map
    for (int n = 0; n < 8; n++) begin
      dat = 32'h1000_0000 | (randBits(26) << 2);
      wbWrite(dat, randBits(32));
      checkOutputs(expHex, expLed, 1'b0);
      wbRead(dat, "unmapped address", '0);
    end

    // ==============================
    // Interval timer
    // ==============================
    limitVal = 20 + randBits(6) % 41;
    wbWrite(TctrlAdr, 32'h10);
    wbWrite(LimitAdr, limitVal);
    wbRead(LimitAdr, "timer limit", limitVal);
    wbWrite(CountAdr, '0);
    start = cycles;
    gotReady = 1'b0;
    while (!gotReady && (cycles - start) < 200) begin
      wbAccess(1'b0, CountAdr, '0, rdWord);
      assert (rdWord < limitVal)
        else reportFail($sformatf("ERR %0t: count %0d not below limit %0d",
                                  $time, rdWord, limitVal));
      wbAccess(1'b0, TctrlAdr, '0, rdWord);
      gotReady = rdWord[`IO_BIT_READY];
    end
    assert (gotReady) else reportFail("timer ready wait expired after 200 cycles");
    checkOutputs(expHex, expLed, 1'b1);
    wbWrite(CountAdr, '0);
    wbWrite(TctrlAdr, '0);
    wbRead(TctrlAdr, "timer control after clear", '0);
    checkOutputs(expHex, expLed, 1'b0);
    // Two wraps without a clear
    waitCycles(2 * int'(limitVal) + 4);
    wbRead(TctrlAdr, "timer control after overrun", 32'h3);

    // ==============================
    // Keys
    // ==============================
    wbWrite(KctrlAdr, 32'h10);
    pat = keyVal_t'(randBits(4));
    if (keyVal_t'(~pat) == expKey) pat = pat ^ 4'h1;
    expKey = ~pat;
    holdKeys(pat);
    wbRead(KctrlAdr, "key control with new data", 32'h11);
    checkOutputs(expHex, expLed, 1'b1);
    wbRead(KeyAdr, "key data", ioWord_t'(expKey));
    checkOutputs(expHex, expLed, 1'b0);
    wbRead(KctrlAdr, "key control after data read", 32'h10);
    for (int n = 0; n < 2; n++) begin
      pat = keyVal_t'(randBits(4));
      if (keyVal_t'(~pat) == expKey) pat = pat ^ 4'h1;
      expKey = ~pat;
      holdKeys(pat);
    end
    wbRead(KctrlAdr, "key control after overrun", 32'h13);
    wbWrite(KctrlAdr, 32'h11);
    wbRead(KctrlAdr, "key control after overrun clear", 32'h11);
    wbRead(KeyAdr, "key data after overrun", ioWord_t'(expKey));
    wbRead(KctrlAdr, "key control at end", 32'h10);
    checkOutputs(expHex, expLed, 1'b0);

    $display("test passed");
    $finish;
  end

endmodule

// ==== verif/ioTop_chk.sv ====
`timescale 1ns/10ps

module ioTop_chk (
  input logic          clk,
  input logic          RESET,
  input ioPkg::wbReq_t wbReq,
  input ioPkg::wbRsp_t wbRsp,
  input logic          intReq
);

  // ==============================
  // Bus handshake
  // ==============================
  // Ack lasts exactly one cycle
  ackSingle: assert property (@(posedge clk) disable iff (RESET)
    wbRsp.ack |=> !wbRsp.ack)
    else $error("ack stayed high for two cycles");

  // Ack only answers a request seen in the cycle before
  ackAfterReq: assert property (@(posedge clk) disable iff (RESET)
    wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
    else $error("ack without a request in the previous cycle");

  // Quiet outputs while reset is held
  quietInReset: assert property (@(posedge clk)
    RESET |-> (!wbRsp.ack && !intReq))
    else $error("ack or intReq high during reset");

endmodule

bind ioTop ioTop_chk u_chk (
  .clk(clk), .RESET(RESET), .wbReq(wbReq), .wbRsp(wbRsp), .intReq(intReq)
);
